/* Makefile */
TOP = imuldiv_int_mul_variable_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f imuldiv_int_mul_variable.f -o sim

run: compile
	./obj_dir/sim | tee sim.log
	@if grep -q "Regression failed" sim.log || ! grep -q "Regression passed" sim.log; then \
		exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* hdl/imuldiv_ctrl_pkg.sv */
package imuldiv_ctrl_pkg;

  // multiplier fsm states.
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } ctrl_state_e;

  // source of the operand and result registers.
  typedef enum logic {
    op_load = 1'b0,
    op_next = 1'b1
  } op_sel_e;

  // keep the partial sum or add the shifted multiplicand.
  typedef enum logic {
    add_old  = 1'b0,
    add_next = 1'b1
  } add_sel_e;

  // output correction, magnitude or negated.
  typedef enum logic {
    sign_u = 1'b0,
    sign_s = 1'b1
  } sign_sel_e;

endpackage

/* hdl/imuldiv_int_mul_variable.sv */
module imuldiv_int_mul_variable #(
  parameter int XLEN = imuldiv_params_pkg::xlen,
  localparam int SHAMT_W = $clog2(XLEN)
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  logic [XLEN-1:0]     a,
  input  logic [XLEN-1:0]     b,
  output logic                busy,
  output logic                done,
  output logic [2*XLEN-1:0]   result
);

  logic                        sign_en;
  logic                        result_en;
  logic                        sign;
  logic [XLEN-1:0]             b_data;
  logic [SHAMT_W-1:0]          op_shamt;
  imuldiv_ctrl_pkg::op_sel_e   a_mux_sel;
  imuldiv_ctrl_pkg::op_sel_e   b_mux_sel;
  imuldiv_ctrl_pkg::op_sel_e   result_mux_sel;
  imuldiv_ctrl_pkg::add_sel_e  add_mux_sel;
  imuldiv_ctrl_pkg::sign_sel_e sign_mux_sel;

  imuldiv_int_mul_variable_ctrl #(
    .XLEN(XLEN)
  ) ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .start          (start),
    .b_data         (b_data),
    .sign           (sign),
    .busy           (busy),
    .done           (done),
    .sign_en        (sign_en),
    .result_en      (result_en),
    .a_mux_sel      (a_mux_sel),
    .b_mux_sel      (b_mux_sel),
    .result_mux_sel (result_mux_sel),
    .add_mux_sel    (add_mux_sel),
    .sign_mux_sel   (sign_mux_sel)
  );

  imuldiv_zero_skip #(
    .XLEN(XLEN)
  ) zero_skip (
    .b_data   (b_data),
    .op_shamt (op_shamt)
  );

  imuldiv_int_mul_variable_dpath #(
    .XLEN(XLEN)
  ) dpath (
    .clk                (clk),
    .rst_n              (rst_n),
    .mulreq_msg_a       (a),
    .mulreq_msg_b       (b),
    .sign_en            (sign_en),
    .result_en          (result_en),
    .a_mux_sel          (a_mux_sel),
    .b_mux_sel          (b_mux_sel),
    .op_shamt           (op_shamt),
    .result_mux_sel     (result_mux_sel),
    .add_mux_sel        (add_mux_sel),
    .sign_mux_sel       (sign_mux_sel),
    .mulresp_msg_result (result),
    .sign               (sign),
    .b_data             (b_data)
  );

endmodule

/* hdl/imuldiv_int_mul_variable_ctrl.sv */
module imuldiv_int_mul_variable_ctrl #(
  parameter int XLEN = imuldiv_params_pkg::xlen
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start,
  input  logic [XLEN-1:0]               b_data,
  input  logic                          sign,
  output logic                          busy,
  output logic                          done,
  output logic                          sign_en,
  output logic                          result_en,
  output imuldiv_ctrl_pkg::op_sel_e     a_mux_sel,
  output imuldiv_ctrl_pkg::op_sel_e     b_mux_sel,
  output imuldiv_ctrl_pkg::op_sel_e     result_mux_sel,
  output imuldiv_ctrl_pkg::add_sel_e    add_mux_sel,
  output imuldiv_ctrl_pkg::sign_sel_e   sign_mux_sel
);

  imuldiv_ctrl_pkg::ctrl_state_e state;
  imuldiv_ctrl_pkg::ctrl_state_e state_next;
  logic                          b_empty;

  // remaining multiplier exhausted.
  assign b_empty = (b_data == '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= imuldiv_ctrl_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      imuldiv_ctrl_pkg::st_idle: begin
        if (start) begin
          state_next = imuldiv_ctrl_pkg::st_calc;
        end
      end
      imuldiv_ctrl_pkg::st_calc: begin
        if (b_empty) begin
          state_next = imuldiv_ctrl_pkg::st_done;
        end
      end
      imuldiv_ctrl_pkg::st_done: begin
        state_next = imuldiv_ctrl_pkg::st_idle;
      end
      default: begin
        state_next = imuldiv_ctrl_pkg::st_idle;
      end
    endcase
  end

  // datapath controls.
  always_comb begin
    sign_en        = 1'b0;
    result_en      = 1'b0;
    a_mux_sel      = imuldiv_ctrl_pkg::op_next;
    b_mux_sel      = imuldiv_ctrl_pkg::op_next;
    result_mux_sel = imuldiv_ctrl_pkg::op_next;
    add_mux_sel    = imuldiv_ctrl_pkg::add_old;
    case (state)
      imuldiv_ctrl_pkg::st_idle: begin
        if (start) begin
          sign_en        = 1'b1;
          result_en      = 1'b1;
          a_mux_sel      = imuldiv_ctrl_pkg::op_load;
          b_mux_sel      = imuldiv_ctrl_pkg::op_load;
          result_mux_sel = imuldiv_ctrl_pkg::op_load;
        end
      end
      imuldiv_ctrl_pkg::st_calc: begin
        result_en = 1'b1;
        if (b_data[0]) begin
          add_mux_sel = imuldiv_ctrl_pkg::add_next;
        end
      end
      default: begin
      end
    endcase
  end

  // keep the corrected product visible outside the loop.
  assign sign_mux_sel = (sign && state != imuldiv_ctrl_pkg::st_calc) ?
                        imuldiv_ctrl_pkg::sign_s : imuldiv_ctrl_pkg::sign_u;

  assign busy = (state != imuldiv_ctrl_pkg::st_idle);
  assign done = (state == imuldiv_ctrl_pkg::st_done);

endmodule

/* hdl/imuldiv_int_mul_variable_dpath.sv */
module imuldiv_int_mul_variable_dpath #(
  parameter int XLEN = imuldiv_params_pkg::xlen,
  localparam int SHAMT_W = $clog2(XLEN),
  localparam int PW = 2 * XLEN
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [XLEN-1:0]               mulreq_msg_a,
  input  logic [XLEN-1:0]               mulreq_msg_b,
  input  logic                          sign_en,
  input  logic                          result_en,
  input  imuldiv_ctrl_pkg::op_sel_e     a_mux_sel,
  input  imuldiv_ctrl_pkg::op_sel_e     b_mux_sel,
  input  logic [SHAMT_W-1:0]            op_shamt,
  input  imuldiv_ctrl_pkg::op_sel_e     result_mux_sel,
  input  imuldiv_ctrl_pkg::add_sel_e    add_mux_sel,
  input  imuldiv_ctrl_pkg::sign_sel_e   sign_mux_sel,
  output logic [PW-1:0]                 mulresp_msg_result,
  output logic                          sign,
  output logic [XLEN-1:0]               b_data
);

  logic            sign_reg;
  logic            sign_next;
  logic [XLEN-1:0] unsigned_a;
  logic [XLEN-1:0] unsigned_b;
  logic [PW-1:0]   a_reg;
  logic [XLEN-1:0] b_reg;
  logic [PW-1:0]   result_reg;
  logic [PW-1:0]   a_mux_out;
  logic [XLEN-1:0] b_mux_out;
  logic [PW-1:0]   add_out;
  logic [PW-1:0]   add_mux_out;
  logic [PW-1:0]   result_mux_out;

  // product is negative when exactly one operand is.
  assign sign_next = mulreq_msg_a[XLEN-1] ^ mulreq_msg_b[XLEN-1];

  // magnitudes. the most negative value maps onto itself as unsigned.
  assign unsigned_a = mulreq_msg_a[XLEN-1] ? -mulreq_msg_a : mulreq_msg_a;
  assign unsigned_b = mulreq_msg_b[XLEN-1] ? -mulreq_msg_b : mulreq_msg_b;

  // multiplicand moves left, multiplier right, by the same amount.
  assign a_mux_out = (a_mux_sel == imuldiv_ctrl_pkg::op_load) ?
                     {{XLEN{1'b0}}, unsigned_a} : (a_reg << op_shamt);
  assign b_mux_out = (b_mux_sel == imuldiv_ctrl_pkg::op_load) ?
                     unsigned_b : (b_reg >> op_shamt);

  assign add_out = result_reg + a_reg;

  assign add_mux_out = (add_mux_sel == imuldiv_ctrl_pkg::add_next) ? add_out : result_reg;

  assign result_mux_out = (result_mux_sel == imuldiv_ctrl_pkg::op_load) ?
                          '0 : add_mux_out;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sign_reg   <= 1'b0;
      a_reg      <= '0;
      b_reg      <= '0;
      result_reg <= '0;
    end else begin
      if (sign_en) begin
        sign_reg <= sign_next;
      end
      if (result_en) begin
        result_reg <= result_mux_out;
      end
      a_reg <= a_mux_out;
      b_reg <= b_mux_out;
    end
  end

  assign sign   = sign_reg;
  assign b_data = b_reg;

  // sign correction on the way out.
  assign mulresp_msg_result = (sign_mux_sel == imuldiv_ctrl_pkg::sign_s) ?
                              -result_reg : result_reg;

endmodule

/* hdl/imuldiv_params_pkg.sv */
package imuldiv_params_pkg;

  // default operand width.
  localparam int unsigned xlen = 32;

  // shift amount wide enough for any bit position in an operand.
  localparam int unsigned shamt_w = $clog2(xlen);

  // full signed product.
  localparam int unsigned prod_w = 2 * xlen;

endpackage

/* hdl/imuldiv_zero_skip.sv */
module imuldiv_zero_skip #(
  parameter int XLEN = imuldiv_params_pkg::xlen,
  localparam int SHAMT_W = $clog2(XLEN)
) (
  input  logic [XLEN-1:0]    b_data,
  output logic [SHAMT_W-1:0] op_shamt
);

  // bit 0 is the one being consumed this cycle, so the search
  // starts one above it.
  always_comb begin
    // nothing left above bit 0, so drain the register in one go.
    op_shamt = SHAMT_W'(XLEN - 1);
    // scan downward so the lowest set bit is the last one written.
    for (int i = XLEN - 1; i >= 1; i--) begin
      if (b_data[i]) begin
        op_shamt = SHAMT_W'(i);
      end
    end
  end

endmodule

/* imuldiv_int_mul_variable.f */
hdl/imuldiv_params_pkg.sv
hdl/imuldiv_ctrl_pkg.sv
hdl/imuldiv_int_mul_variable_dpath.sv
hdl/imuldiv_zero_skip.sv
hdl/imuldiv_int_mul_variable_ctrl.sv
hdl/imuldiv_int_mul_variable.sv
verification/imuldiv_int_mul_variable_checker.sv
verification/imuldiv_int_mul_variable_tb.sv

/* verification/imuldiv_int_mul_variable_checker.sv */
module imuldiv_int_mul_variable_checker #(
  parameter int XLEN = imuldiv_params_pkg::xlen
) (
  input logic clk,
  input logic rst_n,
  input logic start,
  input logic busy,
  input logic done
);

  // cycles since the last accepted start.
  int wait_cycles;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_cycles <= 0;
    end else if (start && !busy) begin
      wait_cycles <= 1;
    end else if (busy) begin
      wait_cycles <= wait_cycles + 1;
    end
  end

  done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done stayed high for more than one cycle");

  done_then_idle: assert property (@(posedge clk) disable iff (!rst_n) done |=> !busy)
    else $error("busy still high in the cycle after done");

  start_sets_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (start && !busy) |=> busy)
    else $error("busy did not rise after an accepted start");

  latency_bound: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> (wait_cycles <= XLEN + 2))
    else $error("done arrived %0d cycles after start", wait_cycles);

endmodule

bind imuldiv_int_mul_variable imuldiv_int_mul_variable_checker #(
  .XLEN(XLEN)
) mul_checker (
  .clk   (clk),
  .rst_n (rst_n),
  .start (start),
  .busy  (busy),
  .done  (done)
);

/* verification/imuldiv_int_mul_variable_tb.sv */
module imuldiv_int_mul_variable_tb;

  localparam int XLEN = imuldiv_params_pkg::xlen;
  localparam int PW = imuldiv_params_pkg::prod_w;
  localparam int N_DIRECTED = 16;
  localparam int N_RANDOM = 400;
  localparam int N_STRAY = 2;
  // full drain of the multiplier plus start and wait slack per operation.
  localparam int MAX_CYCLES = (N_DIRECTED + N_RANDOM + N_STRAY) * (XLEN + 4) + 3;

  localparam logic [XLEN-1:0] ONE = XLEN'(1);
  localparam logic [XLEN-1:0] ONES = '1;
  localparam logic [XLEN-1:0] MIN_VAL = {1'b1, {(XLEN-1){1'b0}}};
  localparam logic [XLEN-1:0] MAX_VAL = {1'b0, {(XLEN-1){1'b1}}};
  localparam logic [XLEN-1:0] ALT_LO = {(XLEN/2){2'b01}};
  localparam logic [XLEN-1:0] ALT_HI = {(XLEN/2){2'b10}};

  logic            clk = 1'b0;
  logic            rst_n;
  logic            start;
  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic            busy;
  logic            done;
  logic [PW-1:0]   result;

  logic [XLEN-1:0] op_a = '0;
  logic [XLEN-1:0] op_b = '0;
  logic            holding = 1'b0;
  int              cycle_count = 0;

  imuldiv_int_mul_variable #(
    .XLEN(XLEN)
  ) uut (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .a      (a),
    .b      (b),
    .busy   (busy),
    .done   (done),
    .result (result)
  );

  always #2 clk = ~clk;

  // signed product of the sign-extended operands.
  function automatic logic [PW-1:0] ref_product(input logic [XLEN-1:0] x,
                                                input logic [XLEN-1:0] y);
    logic signed [PW-1:0] xs;
    logic signed [PW-1:0] ys;
    xs = {{XLEN{x[XLEN-1]}}, x};
    ys = {{XLEN{y[XLEN-1]}}, y};
    return xs * ys;
  endfunction

  task automatic check_value(input string name, input logic [PW-1:0] got,
                             input logic [PW-1:0] expected);
    if (got !== expected) begin
      $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, expected);
      $display("Regression failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic issue_start(input logic [XLEN-1:0] x, input logic [XLEN-1:0] y);
    @(negedge clk);
    while (busy) @(negedge clk);
    @(posedge clk);
    start <= 1'b1;
    a <= x;
    b <= y;
    @(posedge clk);
    start <= 1'b0;
    // operands only matter in the start cycle.
    a <= ~x;
    b <= ~y;
  endtask

  task automatic wait_for_done();
    @(negedge clk);
    while (!done) @(negedge clk);
  endtask

  task automatic run_op(input logic [XLEN-1:0] x, input logic [XLEN-1:0] y);
    issue_start(x, y);
    wait_for_done();
  endtask

  // second start lands mid-calculation, then inputs wander while idle.
  task automatic run_with_stray_start(input logic [XLEN-1:0] x, input logic [XLEN-1:0] y);
    issue_start(x, y);
    repeat (3) @(posedge clk);
    start <= 1'b1;
    a <= XLEN'($urandom);
    b <= XLEN'($urandom);
    @(posedge clk);
    start <= 1'b0;
    wait_for_done();
    repeat (4) begin
      @(posedge clk);
      a <= XLEN'($urandom);
      b <= XLEN'($urandom);
    end
  endtask

  // compares at the falling edge, where all DUT outputs are settled.
  always @(negedge clk) begin
    if (rst_n) begin
      if (done || holding) begin
        check_value("result", result, ref_product(op_a, op_b));
      end
      if (done) begin
        holding = 1'b1;
      end
      if (start && !busy) begin
        op_a = a;
        op_b = b;
        holding = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Regression failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    logic [XLEN-1:0] x;
    logic [XLEN-1:0] y;
    void'($urandom(70));
    rst_n = 1'b0;
    start = 1'b0;
    a = '0;
    b = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("busy", PW'(busy), '0);
    check_value("done", PW'(done), '0);
    check_value("result", result, '0);

    run_op('0, XLEN'(32'h1234_5678));
    run_op(XLEN'(32'h89ab_cdef), '0);
    run_op(ONE, ONES);
    run_op(ONES, ONE);
    run_op(MIN_VAL, ONES);
    run_op(MIN_VAL, MIN_VAL);
    run_op(MAX_VAL, MAX_VAL);
    run_op(XLEN'(-12345), XLEN'(6789));
    run_op(XLEN'(1000), XLEN'(-77));
    run_op(ONES, ONES);

    // sparse and dense multipliers for the zero skip.
    run_op(XLEN'(32'h0bad_cafe), MIN_VAL);
    run_op(XLEN'(32'h0000_7531), ONE << (XLEN - 2));
    run_op(XLEN'(-3), ALT_LO);
    run_op(XLEN'(32'h1357_9bdf), ALT_HI);
    run_op(XLEN'(-5), MAX_VAL);

    run_with_stray_start(XLEN'(-987654), MAX_VAL);

    for (int i = 0; i < N_RANDOM; i++) begin
      x = XLEN'($urandom);
      y = XLEN'($urandom);
      run_op(x, y);
    end

    repeat (2) @(negedge clk);
    $display("Regression passed");
    $finish;
  end

endmodule
